//--- cpu_pkg.sv
package cpu_pkg;

    localparam int WORD_W     = 32;                 // Data path width
    localparam int REG_ADDR_W = 5;                  // 32 general registers
    localparam int MEM_DEPTH  = 64;                 // Data memory words
    localparam int MEM_ADDR_W = $clog2(MEM_DEPTH);  // Word index bits

    // ALU operation, NOP gives zero
    typedef enum logic [2:0] {
        ALU_NOP = 3'd0,
        ALU_ADD = 3'd1,
        ALU_SUB = 3'd2,
        ALU_AND = 3'd3,
        ALU_OR  = 3'd4,
        ALU_XOR = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        CMP_NONE = 2'd0,
        CMP_LT   = 2'd1,  // Signed
        CMP_LTU  = 2'd2   // Unsigned
    } cmp_op_e;

    typedef enum logic [1:0] {
        MEM_NOP   = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // Source of the EX stage result
    typedef enum logic [1:0] {
        EX_OUT_ALU  = 2'd0,
        EX_OUT_CMP  = 2'd1,
        EX_OUT_ZERO = 2'd2
    } ex_out_sel_e;

endpackage

//--- isa_pkg.sv
package isa_pkg;

    // Major opcode, top 6 bits of every instruction
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,  // Register-register, operation in funct
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0a,  // Signed compare against immediate
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // R-form function field
    typedef enum logic [10:0] {
        F_ADD  = 11'h020,
        F_SUB  = 11'h022,
        F_AND  = 11'h024,
        F_OR   = 11'h025,
        F_XOR  = 11'h026,
        F_SLT  = 11'h02a,  // Signed less than
        F_SLTU = 11'h02b   // Unsigned less than
    } funct_e;

    // Same 32-bit word seen as R-form or I-form
    // I-form rd sits where R-form rb sits, so SW reads store data through it
    typedef union packed {
        struct packed {
            opcode_e     opcode;
            logic [4:0]  ra;
            logic [4:0]  rb;
            logic [4:0]  rd;
            funct_e      funct;
        } r;
        struct packed {
            opcode_e            opcode;
            logic [4:0]         ra;
            logic [4:0]         rd;
            logic signed [15:0] imm;  // Sign-extended in decode
        } i;
    } instr_t;

endpackage

//--- alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [cpu_pkg::WORD_W-1:0] arg0,
    input  logic [cpu_pkg::WORD_W-1:0] arg1,
    input  cpu_pkg::alu_op_e           op,
    output logic [cpu_pkg::WORD_W-1:0] val
);
    import cpu_pkg::*;

    // Pure combinational, no flags
    always_comb begin
        case (op)
            ALU_ADD: begin
                val = arg0 + arg1;  // Also address generation
            end
            ALU_SUB: begin
                val = arg0 - arg1;
            end
            ALU_AND: begin
                val = arg0 & arg1;
            end
            ALU_OR: begin
                val = arg0 | arg1;
            end
            ALU_XOR: begin
                val = arg0 ^ arg1;
            end
            default: begin
                val = '0;  // ALU_NOP
            end
        endcase
    end

endmodule

//--- id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           instr_valid,
    input  isa_pkg::instr_t                instr,
    input  logic [cpu_pkg::WORD_W-1:0]     fwd_data,      // Result of instruction in EX
    input  logic                           ex_en,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_dst_addr,
    input  logic                           ex_gpr_we_,
    input  logic [cpu_pkg::WORD_W-1:0]     mem_fwd_data,  // Result of instruction in MEM
    input  logic                           wb_en,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [cpu_pkg::WORD_W-1:0]     wb_data,
    output logic                           id_en,
    output cpu_pkg::alu_op_e               id_alu_op,
    output logic [cpu_pkg::WORD_W-1:0]     id_alu_in_0,
    output logic [cpu_pkg::WORD_W-1:0]     id_alu_in_1,
    output cpu_pkg::cmp_op_e               id_cmp_op,
    output logic [cpu_pkg::WORD_W-1:0]     id_cmp_in_0,
    output logic [cpu_pkg::WORD_W-1:0]     id_cmp_in_1,
    output cpu_pkg::mem_op_e               id_mem_op,
    output logic [cpu_pkg::WORD_W-1:0]     id_mem_wr_data,
    output logic [cpu_pkg::REG_ADDR_W-1:0] id_dst_addr,
    output logic                           id_gpr_we_,    // Active low
    output cpu_pkg::ex_out_sel_e           ex_out_sel
);
    import cpu_pkg::*;
    import isa_pkg::*;

    logic [WORD_W-1:0]     gpr [0:2**REG_ADDR_W-1];  // Register file, r0 never written
    logic [WORD_W-1:0]     ra_data;
    logic [WORD_W-1:0]     rb_data;                  // Also store data for SW
    logic [WORD_W-1:0]     imm_ext;
    alu_op_e               d_alu_op;
    cmp_op_e               d_cmp_op;
    mem_op_e               d_mem_op;
    ex_out_sel_e           d_out_sel;
    logic [WORD_W-1:0]     d_alu_in_1;
    logic [WORD_W-1:0]     d_cmp_in_1;
    logic [REG_ADDR_W-1:0] d_dst;
    logic                  d_gpr_we_;

    // Operand read with forwarding, youngest producer wins
    function automatic logic [WORD_W-1:0] read_src(input logic [REG_ADDR_W-1:0] addr);
        logic [WORD_W-1:0] val;
        if (addr == '0)
            val = '0;                                  // r0 hardwired
        else if (id_en && !id_gpr_we_ && id_dst_addr == addr)
            val = fwd_data;                            // Producer one ahead, now in EX
        else if (ex_en && !ex_gpr_we_ && ex_dst_addr == addr)
            val = mem_fwd_data;                        // Two ahead, now in MEM
        else
            val = gpr[addr];
        return val;
    endfunction

    always_comb begin
        ra_data = read_src(instr.r.ra);
        rb_data = read_src(instr.r.rb);  // Same bits as i.rd
    end

    assign imm_ext = {{(WORD_W-16){instr.i.imm[15]}}, instr.i.imm};

    always_comb begin
        d_alu_op   = ALU_NOP;
        d_cmp_op   = CMP_NONE;
        d_mem_op   = MEM_NOP;
        d_out_sel  = EX_OUT_ZERO;
        d_alu_in_1 = imm_ext;  // I-form default
        d_cmp_in_1 = imm_ext;
        d_dst      = instr.i.rd;
        d_gpr_we_  = 1'b1;
        case (instr.r.opcode)
            OP_RTYPE: begin
                d_alu_in_1 = rb_data;
                d_cmp_in_1 = rb_data;
                d_dst      = instr.r.rd;
                d_gpr_we_  = 1'b0;
                d_out_sel  = EX_OUT_ALU;
                case (instr.r.funct)
                    F_ADD:   d_alu_op = ALU_ADD;
                    F_SUB:   d_alu_op = ALU_SUB;
                    F_AND:   d_alu_op = ALU_AND;
                    F_OR:    d_alu_op = ALU_OR;
                    F_XOR:   d_alu_op = ALU_XOR;
                    F_SLT: begin
                        d_cmp_op  = CMP_LT;
                        d_out_sel = EX_OUT_CMP;
                    end
                    F_SLTU: begin
                        d_cmp_op  = CMP_LTU;
                        d_out_sel = EX_OUT_CMP;
                    end
                    default: begin
                        d_gpr_we_ = 1'b1;  // Unknown funct, treated as NOP
                        d_out_sel = EX_OUT_ZERO;
                    end
                endcase
            end
            OP_ADDI: begin
                d_alu_op  = ALU_ADD;
                d_out_sel = EX_OUT_ALU;
                d_gpr_we_ = 1'b0;
            end
            OP_SLTI: begin
                d_cmp_op  = CMP_LT;
                d_out_sel = EX_OUT_CMP;
                d_gpr_we_ = 1'b0;
            end
            OP_LW: begin
                d_alu_op  = ALU_ADD;  // Address ra + imm
                d_out_sel = EX_OUT_ALU;
                d_mem_op  = MEM_LOAD;
                d_gpr_we_ = 1'b0;
            end
            OP_SW: begin
                d_alu_op  = ALU_ADD;
                d_out_sel = EX_OUT_ALU;
                d_mem_op  = MEM_STORE;  // No register write
            end
            default: ;
        endcase
    end

    // ID/EX control, bubbles made inert
    always_ff @(posedge clk) begin
        if (reset) begin
            id_en      <= 1'b0;
            id_gpr_we_ <= 1'b1;
            id_alu_op  <= ALU_NOP;
            id_cmp_op  <= CMP_NONE;
            id_mem_op  <= MEM_NOP;
            ex_out_sel <= EX_OUT_ZERO;
        end else begin
            id_en      <= instr_valid;
            id_gpr_we_ <= instr_valid ? d_gpr_we_ : 1'b1;
            id_alu_op  <= d_alu_op;
            id_cmp_op  <= d_cmp_op;
            id_mem_op  <= instr_valid ? d_mem_op : MEM_NOP;
            ex_out_sel <= d_out_sel;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        id_alu_in_0    <= ra_data;
        id_alu_in_1    <= d_alu_in_1;
        id_cmp_in_0    <= ra_data;
        id_cmp_in_1    <= d_cmp_in_1;
        id_mem_wr_data <= rb_data;
        id_dst_addr    <= d_dst;
    end

    // Write port, lands at end of the MEM cycle
    always_ff @(posedge clk) begin
        if (wb_en)
            gpr[wb_addr] <= wb_data;
    end

endmodule

//--- ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           id_en,
    input  cpu_pkg::alu_op_e               id_alu_op,
    input  logic [cpu_pkg::WORD_W-1:0]     id_alu_in_0,
    input  logic [cpu_pkg::WORD_W-1:0]     id_alu_in_1,
    input  cpu_pkg::cmp_op_e               id_cmp_op,
    input  logic [cpu_pkg::WORD_W-1:0]     id_cmp_in_0,
    input  logic [cpu_pkg::WORD_W-1:0]     id_cmp_in_1,
    input  cpu_pkg::mem_op_e               id_mem_op,
    input  logic [cpu_pkg::WORD_W-1:0]     id_mem_wr_data,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] id_dst_addr,
    input  logic                           id_gpr_we_,
    input  cpu_pkg::ex_out_sel_e           ex_out_sel,
    output logic [cpu_pkg::WORD_W-1:0]     fwd_data,     // Back to decode
    output logic [cpu_pkg::WORD_W-1:0]     alu_out,
    output logic                           ex_en,
    output cpu_pkg::mem_op_e               ex_mem_op,
    output logic [cpu_pkg::WORD_W-1:0]     ex_mem_wr_data,
    output logic [cpu_pkg::REG_ADDR_W-1:0] ex_dst_addr,
    output logic                           ex_gpr_we_,
    output logic [cpu_pkg::WORD_W-1:0]     ex_out,
    output logic                           access_mem    // Load or store in MEM
);
    import cpu_pkg::*;

    logic              cmp_out;
    logic [WORD_W-1:0] ex_out_inner;

    alu alu_i (
        .arg0 (id_alu_in_0),
        .arg1 (id_alu_in_1),
        .op   (id_alu_op),
        .val  (alu_out)
    );

    // Compare inline, signedness by op
    always_comb begin
        case (id_cmp_op)
            CMP_LT:  cmp_out = $signed(id_cmp_in_0) < $signed(id_cmp_in_1);
            CMP_LTU: cmp_out = id_cmp_in_0 < id_cmp_in_1;
            default: cmp_out = 1'b0;
        endcase
    end

    always_comb begin
        case (ex_out_sel)
            EX_OUT_ALU: ex_out_inner = alu_out;
            EX_OUT_CMP: ex_out_inner = {{(WORD_W-1){1'b0}}, cmp_out};  // Zero-extended
            default:    ex_out_inner = '0;
        endcase
    end

    assign fwd_data = ex_out_inner;  // Same value EX/MEM will capture

    // EX/MEM control
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_en      <= 1'b0;
            ex_gpr_we_ <= 1'b1;
            ex_mem_op  <= MEM_NOP;
            access_mem <= 1'b0;
        end else begin
            ex_en      <= id_en;
            ex_gpr_we_ <= id_gpr_we_;
            ex_mem_op  <= id_mem_op;
            access_mem <= id_en && (id_mem_op != MEM_NOP);
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        ex_mem_wr_data <= id_mem_wr_data;
        ex_dst_addr    <= id_dst_addr;
        ex_out         <= ex_out_inner;  // Result or memory address
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           ex_en,
    input  cpu_pkg::mem_op_e               ex_mem_op,
    input  logic [cpu_pkg::WORD_W-1:0]     ex_mem_wr_data,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_dst_addr,
    input  logic                           ex_gpr_we_,
    input  logic [cpu_pkg::WORD_W-1:0]     ex_out,
    input  logic                           access_mem,
    output logic [cpu_pkg::WORD_W-1:0]     mem_fwd_data,
    output logic                           wb_en,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [cpu_pkg::WORD_W-1:0]     wb_data
);
    import cpu_pkg::*;

    logic [WORD_W-1:0]     dmem [0:MEM_DEPTH-1];
    logic [MEM_ADDR_W-1:0] word_idx;
    logic [WORD_W-1:0]     result;
    logic                  is_load;
    logic                  is_store;

    assign word_idx = ex_out[MEM_ADDR_W+1:2];  // Byte address, word aligned
    assign is_load  = access_mem && ex_mem_op == MEM_LOAD;
    assign is_store = ex_en && access_mem && ex_mem_op == MEM_STORE;

    // Write at end of MEM cycle, held off in reset
    always_ff @(posedge clk) begin
        if (!reset && is_store)
            dmem[word_idx] <= ex_mem_wr_data;
    end

    // Asynchronous read
    assign result = is_load ? dmem[word_idx] : ex_out;

    assign mem_fwd_data = result;
    assign wb_data      = result;
    assign wb_addr      = ex_dst_addr;
    assign wb_en        = ex_en && !ex_gpr_we_ && ex_dst_addr != '0;  // Never r0

endmodule

//--- cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           instr_valid,
    input  isa_pkg::instr_t                instr,
    output logic                           wb_en,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [cpu_pkg::WORD_W-1:0]     wb_data
);
    import cpu_pkg::*;

    // ID/EX
    logic                  id_en;
    alu_op_e               id_alu_op;
    logic [WORD_W-1:0]     id_alu_in_0;
    logic [WORD_W-1:0]     id_alu_in_1;
    cmp_op_e               id_cmp_op;
    logic [WORD_W-1:0]     id_cmp_in_0;
    logic [WORD_W-1:0]     id_cmp_in_1;
    mem_op_e               id_mem_op;
    logic [WORD_W-1:0]     id_mem_wr_data;
    logic [REG_ADDR_W-1:0] id_dst_addr;
    logic                  id_gpr_we_;
    ex_out_sel_e           ex_out_sel;
    // EX/MEM and forwarding paths
    logic [WORD_W-1:0]     fwd_data;
    logic                  ex_en;
    mem_op_e               ex_mem_op;
    logic [WORD_W-1:0]     ex_mem_wr_data;
    logic [REG_ADDR_W-1:0] ex_dst_addr;
    logic                  ex_gpr_we_;
    logic [WORD_W-1:0]     ex_out;
    logic                  access_mem;
    logic [WORD_W-1:0]     mem_fwd_data;

    id_stage u_id_stage (
        .clk            (clk),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .fwd_data       (fwd_data),
        .ex_en          (ex_en),
        .ex_dst_addr    (ex_dst_addr),
        .ex_gpr_we_     (ex_gpr_we_),
        .mem_fwd_data   (mem_fwd_data),
        .wb_en          (wb_en),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .id_en          (id_en),
        .id_alu_op      (id_alu_op),
        .id_alu_in_0    (id_alu_in_0),
        .id_alu_in_1    (id_alu_in_1),
        .id_cmp_op      (id_cmp_op),
        .id_cmp_in_0    (id_cmp_in_0),
        .id_cmp_in_1    (id_cmp_in_1),
        .id_mem_op      (id_mem_op),
        .id_mem_wr_data (id_mem_wr_data),
        .id_dst_addr    (id_dst_addr),
        .id_gpr_we_     (id_gpr_we_),
        .ex_out_sel     (ex_out_sel)
    );

    ex_stage u_ex_stage (
        .clk            (clk),
        .reset          (reset),
        .id_en          (id_en),
        .id_alu_op      (id_alu_op),
        .id_alu_in_0    (id_alu_in_0),
        .id_alu_in_1    (id_alu_in_1),
        .id_cmp_op      (id_cmp_op),
        .id_cmp_in_0    (id_cmp_in_0),
        .id_cmp_in_1    (id_cmp_in_1),
        .id_mem_op      (id_mem_op),
        .id_mem_wr_data (id_mem_wr_data),
        .id_dst_addr    (id_dst_addr),
        .id_gpr_we_     (id_gpr_we_),
        .ex_out_sel     (ex_out_sel),
        .fwd_data       (fwd_data),
        .alu_out        (),              // Observed only inside EX
        .ex_en          (ex_en),
        .ex_mem_op      (ex_mem_op),
        .ex_mem_wr_data (ex_mem_wr_data),
        .ex_dst_addr    (ex_dst_addr),
        .ex_gpr_we_     (ex_gpr_we_),
        .ex_out         (ex_out),
        .access_mem     (access_mem)
    );

    mem_stage u_mem_stage (
        .clk            (clk),
        .reset          (reset),
        .ex_en          (ex_en),
        .ex_mem_op      (ex_mem_op),
        .ex_mem_wr_data (ex_mem_wr_data),
        .ex_dst_addr    (ex_dst_addr),
        .ex_gpr_we_     (ex_gpr_we_),
        .ex_out         (ex_out),
        .access_mem     (access_mem),
        .mem_fwd_data   (mem_fwd_data),
        .wb_en          (wb_en),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data)
    );

endmodule

//--- cpu_core_asserts.sv
`timescale 1ns/1ps

module cpu_core_asserts (
    input logic                           clk,
    input logic                           reset,
    input logic                           instr_valid,
    input logic                           wb_en,
    input logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr,
    input logic                           access_mem,
    input cpu_pkg::mem_op_e               ex_mem_op
);
    import cpu_pkg::*;

    // MEM holds nothing right after reset
    wb_quiet_after_reset: assert property (@(posedge clk) reset |=> !wb_en)
        else $error("wb_en high in the cycle after reset");

    wb_never_r0: assert property (@(posedge clk) disable iff (reset)
        wb_en |-> wb_addr != '0)
        else $error("writeback addressed to register 0");

    // Two edges from ID capture to MEM
    id_to_mem_latency: assert property (@(posedge clk) disable iff (reset)
        instr_valid |-> ##2 (wb_en || (access_mem && ex_mem_op == MEM_STORE)))
        else $error("valid instruction gave no writeback or store two cycles later");

endmodule

bind cpu_core cpu_core_asserts u_cpu_core_asserts (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .wb_en       (wb_en),
    .wb_addr     (wb_addr),
    .access_mem  (access_mem),
    .ex_mem_op   (ex_mem_op)
);

//--- tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;
    import cpu_pkg::*;
    import isa_pkg::*;

    localparam int RESET_CYCLES = 3;
    localparam int RAND_GAP     = -1;  // Marks a gap chosen at run start

    logic                  clk;
    logic                  reset;
    logic                  instr_valid;
    instr_t                instr;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [WORD_W-1:0]     wb_data;

    // Stimulus table with one queue per column
    string                 t_name[$];
    logic [31:0]           t_word[$];
    logic                  t_we[$];    // Writeback expected
    logic [REG_ADDR_W-1:0] t_addr[$];
    logic [WORD_W-1:0]     t_data[$];
    int                    t_gap[$];   // Idle cycles before issue

    int   idx_q[$];  // Issued entries not yet seen in MEM
    int   due_q[$];  // Checker cycle at which each reaches MEM
    int   cyc;
    int   errors;
    int   failed_tests;
    int   done_tests;
    int   limit;
    logic limit_ready;

    cpu_core u_cpu_core (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // R-form word built from its fields
    function automatic logic [31:0] r_form(input funct_e funct, input int rd,
                                           input int ra, input int rb);
        return {OP_RTYPE, 5'(ra), 5'(rb), 5'(rd), funct};
    endfunction

    // I-form word where SW puts its data register in rd
    function automatic logic [31:0] i_form(input opcode_e op, input int rd,
                                           input int ra, input int imm);
        return {op, 5'(ra), 5'(rd), 16'(imm)};
    endfunction

    task automatic add_test(input string name, input logic [31:0] word, input logic we,
                            input int addr, input logic [31:0] data, input int gap);
        t_name.push_back(name);
        t_word.push_back(word);
        t_we.push_back(we);
        t_addr.push_back(REG_ADDR_W'(addr));
        t_data.push_back(data);
        t_gap.push_back(gap);
    endtask

    // Expected results worked out by hand in program order
    task automatic build_table();
        add_test("addi_r1_r0", i_form(OP_ADDI, 1, 0, 5), 1'b1, 1, 32'd5, RAND_GAP);
        add_test("addi_neg", i_form(OP_ADDI, 2, 0, -3), 1'b1, 2, 32'hffff_fffd, RAND_GAP);
        add_test("addi_r3", i_form(OP_ADDI, 3, 0, 16'h1234), 1'b1, 3, 32'h1234, RAND_GAP);
        add_test("add", r_form(F_ADD, 4, 1, 2), 1'b1, 4, 32'd2, RAND_GAP);
        add_test("sub", r_form(F_SUB, 5, 1, 2), 1'b1, 5, 32'd8, RAND_GAP);
        add_test("and", r_form(F_AND, 6, 3, 1), 1'b1, 6, 32'd4, RAND_GAP);
        add_test("or", r_form(F_OR, 7, 3, 1), 1'b1, 7, 32'h1235, RAND_GAP);
        add_test("xor", r_form(F_XOR, 8, 3, 2), 1'b1, 8, 32'hffff_edc9, RAND_GAP);
        add_test("slt_neg_pos", r_form(F_SLT, 9, 2, 1), 1'b1, 9, 32'd1, RAND_GAP);
        add_test("sltu_neg_pos", r_form(F_SLTU, 10, 2, 1), 1'b1, 10, 32'd0, RAND_GAP);
        add_test("slt_pos_neg", r_form(F_SLT, 11, 1, 2), 1'b1, 11, 32'd0, RAND_GAP);
        add_test("sltu_pos_neg", r_form(F_SLTU, 12, 1, 2), 1'b1, 12, 32'd1, RAND_GAP);
        add_test("slti_true", i_form(OP_SLTI, 13, 2, -2), 1'b1, 13, 32'd1, RAND_GAP);
        add_test("slti_false", i_form(OP_SLTI, 14, 1, -1), 1'b1, 14, 32'd0, RAND_GAP);
        // Dependent chain without gaps
        add_test("fwd_base", i_form(OP_ADDI, 15, 0, 100), 1'b1, 15, 32'd100, RAND_GAP);
        add_test("fwd_dist1", i_form(OP_ADDI, 16, 15, 1), 1'b1, 16, 32'd101, 0);
        add_test("fwd_dist1_2", r_form(F_ADD, 17, 15, 16), 1'b1, 17, 32'd201, 0);
        add_test("fwd_dist1_3", r_form(F_SUB, 18, 17, 15), 1'b1, 18, 32'd101, 0);
        add_test("fwd_redef", i_form(OP_ADDI, 15, 15, 7), 1'b1, 15, 32'd107, 0);
        add_test("fwd_new_val", r_form(F_ADD, 19, 15, 18), 1'b1, 19, 32'd208, 0);
        add_test("fwd_old_r20", i_form(OP_ADDI, 20, 0, 1), 1'b1, 20, 32'd1, RAND_GAP);
        add_test("fwd_new_r20", i_form(OP_ADDI, 20, 20, 2), 1'b1, 20, 32'd3, 0);
        add_test("fwd_youngest", r_form(F_ADD, 21, 20, 20), 1'b1, 21, 32'd6, 0);
        // Memory tests where no load feeds the next instruction
        add_test("sw_no_wb", i_form(OP_SW, 8, 0, 16), 1'b0, 0, 32'd0, RAND_GAP);
        add_test("lw_after_sw", i_form(OP_LW, 22, 0, 16), 1'b1, 22, 32'hffff_edc9, 0);
        add_test("lw_fwd_dist2", r_form(F_ADD, 23, 22, 1), 1'b1, 23, 32'hffff_edce, 1);
        add_test("sw_data_src", i_form(OP_ADDI, 24, 0, 16'h55), 1'b1, 24, 32'h55, RAND_GAP);
        add_test("sw_fwd_data", i_form(OP_SW, 24, 0, 24), 1'b0, 0, 32'd0, 0);
        add_test("lw_fwd_data", i_form(OP_LW, 25, 0, 24), 1'b1, 25, 32'h55, 0);
        add_test("add_r0_r0", r_form(F_ADD, 26, 0, 0), 1'b1, 26, 32'd0, RAND_GAP);
    endtask

    // Compare one entry against the MEM-stage outputs
    task automatic check_entry(input int idx);
        int bad;
        bad = 0;
        assert (wb_en === t_we[idx]) else begin
            $display("Error: %s wb_en expected %0b actual %0b", t_name[idx], t_we[idx], wb_en);
            bad++;
        end
        if (t_we[idx]) begin
            assert (wb_addr === t_addr[idx]) else begin
                $display("Error: %s wb_addr expected %0d actual %0d",
                         t_name[idx], t_addr[idx], wb_addr);
                bad++;
            end
            assert (wb_data === t_data[idx]) else begin
                $display("Error: %s wb_data expected %h actual %h",
                         t_name[idx], t_data[idx], wb_data);
                bad++;
            end
        end
        if (bad == 0)
            $display("test %-14s ok", t_name[idx]);
        else
            $display("test %-14s failed", t_name[idx]);
        errors += bad;
        failed_tests += (bad != 0) ? 1 : 0;
        done_tests++;
    endtask

    // Outputs sampled mid-cycle away from the driving edge
    initial begin : check_writes
        int idx;
        @(posedge clk);  // Count cycles from the first rising edge
        forever begin
            @(negedge clk);
            cyc = cyc + 1;
            if (due_q.size() != 0 && due_q[0] == cyc) begin
                idx = idx_q.pop_front();
                void'(due_q.pop_front());
                check_entry(idx);
            end else begin
                assert (wb_en !== 1'b1) else begin
                    $display("Unexpected writeback to r%0d at cycle %0d", wb_addr, cyc);
                    errors++;
                end
            end
        end
    end

    initial begin : watchdog
        wait (limit_ready);
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles with %0d results pending",
                 limit, due_q.size());
        $display("** FAIL **");
        $finish;
    end

    initial begin : drive
        int seed_val;
        int total_gap;
        reset        = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        cyc          = 0;
        errors       = 0;
        failed_tests = 0;
        done_tests   = 0;
        limit        = 0;
        limit_ready  = 1'b0;
        seed_val     = $urandom(32'h9400d69b);  // Seeds this thread once
        build_table();
        total_gap = 0;
        foreach (t_gap[i]) begin
            if (t_gap[i] == RAND_GAP)
                t_gap[i] = int'($urandom % 3);  // 0 to 2 idle cycles
            total_gap += t_gap[i];
        end
        limit       = RESET_CYCLES + t_name.size() + total_gap + 10;
        limit_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        foreach (t_word[i]) begin
            repeat (t_gap[i]) begin
                @(posedge clk);
                instr_valid <= 1'b0;
            end
            @(posedge clk);
            instr_valid <= 1'b1;
            instr       <= t_word[i];
            idx_q.push_back(i);
            due_q.push_back(cyc + 3);  // Two pipeline edges and then the MEM sample
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        while (due_q.size() != 0)
            @(negedge clk);
        repeat (2) @(posedge clk);  // Window for stray writebacks
        $display("Tests run %0d, failed %0d, check errors %0d",
                 done_tests, failed_tests, errors);
        if (errors == 0 && done_tests == t_name.size())
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- list.f
cpu_pkg.sv
isa_pkg.sv
alu.sv
id_stage.sv
ex_stage.sv
mem_stage.sv
cpu_core.sv
cpu_core_asserts.sv
tb_cpu_core.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_cpu_core
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG) || ! grep -q '\*\* PASS \*\*' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
